//--- hdl/block_ram.sv
`timescale 1ns/1ps
`default_nettype none

module block_ram
	import capture_pkg::*;
#(
	parameter int BLOCK_DEPTH = DEF_BLOCK_DEPTH
) (
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire                               wr_en_i,
	input  wire  [$clog2(BLOCK_DEPTH+1)-1:0]  wr_addr_i,
	input  word_t                             wr_data_i,
	input  wire                               wb_cyc_i,
	input  wire                               wb_stb_i,
	input  wire                               wb_we_i,
	input  wire  [$clog2(BLOCK_DEPTH+1)-1:0]  wb_adr_i,
	output word_t                             wb_dat_o,
	output logic                              wb_ack_o
);

	localparam int ADDR_W = $clog2(BLOCK_DEPTH + 1);

	// data entries plus the marker word
	word_t mem [BLOCK_DEPTH + 1];

	always_ff @(posedge clk)
	begin
		if (wr_en_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	// addresses past the marker read as zero
	always_ff @(posedge clk)
	begin
		if (wb_cyc_i && wb_stb_i && !wb_we_i)
		begin
			if (wb_adr_i <= ADDR_W'(BLOCK_DEPTH))
				wb_dat_o <= mem[wb_adr_i];
			else
				wb_dat_o <= '0;
		end
	end

	// classic single cycle ack
	// host writes get their ack and change nothing
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			wb_ack_o <= 1'b0;
		else
			wb_ack_o <= wb_cyc_i && wb_stb_i && !wb_ack_o;
	end

endmodule

`default_nettype wire

//--- hdl/block_writer.sv
`timescale 1ns/1ps
`default_nettype none

module block_writer
	import capture_pkg::*;
#(
	parameter int WINDOW_DEPTH = DEF_WINDOW_DEPTH,
	parameter int BLOCK_DEPTH  = DEF_BLOCK_DEPTH
) (
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire                               sample_valid_i,
	output logic                              sample_ready_o,
	input  wire                               release_i,
	output logic                              block_ready_o,
	window_if.writer                          win,
	output logic                              wr_en_o,
	output logic [$clog2(BLOCK_DEPTH+1)-1:0]  wr_addr_o,
	output word_t                             wr_data_o
);

	// data entries plus the marker slot
	localparam int ADDR_W = $clog2(BLOCK_DEPTH + 1);

	writer_state_t     state;
	logic [ADDR_W-1:0] count;
	logic              discard;
	logic              last_entry;

	// break before a full window was copied
	assign discard = (state == IDLE) && win.stored && win.quiet &&
		(count < ADDR_W'(WINDOW_DEPTH));

	assign last_entry = (count == ADDR_W'(BLOCK_DEPTH - 1));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			count <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (win.stored)
					begin
						// break handling first, copy only while armed
						if (win.quiet)
						begin
							if (discard)
								count <= '0;
							else
								state <= PAD;
						end
						else if (win.armed)
							state <= FETCH;
					end
				end
				FETCH:
				begin
					state <= STORE;
				end
				STORE:
				begin
					count <= count + 1'b1;
					if (last_entry)
						state <= MARK;
					else
						state <= IDLE;
				end
				PAD:
				begin
					// one zero word per cycle up to the end
					count <= count + 1'b1;
					if (last_entry)
						state <= MARK;
				end
				MARK:
				begin
					state <= HOLD;
				end
				HOLD:
				begin
					if (release_i)
					begin
						count <= '0;
						state <= IDLE;
					end
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// closed for the cycle after an acceptance and outside IDLE
	assign sample_ready_o = (state == IDLE) && !win.stored;
	assign block_ready_o  = (state == HOLD);

	assign win.fetch = (state == FETCH);
	assign win.clear = discard || ((state == HOLD) && release_i);

	// block memory write port
	always_comb
	begin
		wr_en_o   = 1'b0;
		wr_addr_o = count;
		wr_data_o = '0;
		case (state)
			STORE:
			begin
				wr_en_o   = 1'b1;
				wr_data_o = win.oldest;
			end
			PAD:
			begin
				wr_en_o = 1'b1;
			end
			MARK:
			begin
				wr_en_o   = 1'b1;
				wr_addr_o = ADDR_W'(BLOCK_DEPTH);
				wr_data_o = MARKER_WORD;
			end
			default:
			begin
				wr_en_o = 1'b0;
			end
		endcase
	end

	a_addr_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		wr_en_o |-> (wr_addr_o <= ADDR_W'(BLOCK_DEPTH))
	);

	// host only sees a block once its marker is in memory
	a_ready_after_marker: assert property (
		@(posedge clk) disable iff (!rst_n)
		$rose(block_ready_o) |-> $past(wr_en_o && (wr_data_o == MARKER_WORD) &&
			(wr_addr_o == ADDR_W'(BLOCK_DEPTH)))
	);

	// every acceptance must be followed by the ring's stored pulse
	a_accept_stored: assert property (
		@(posedge clk) disable iff (!rst_n)
		(sample_valid_i && sample_ready_o) |=> win.stored
	);

endmodule

`default_nettype wire

//--- hdl/burst_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module burst_capture_top
	import capture_pkg::*;
#(
	parameter int WINDOW_DEPTH = DEF_WINDOW_DEPTH,
	parameter int BLOCK_DEPTH  = DEF_BLOCK_DEPTH
) (
	input  wire                               clk,
	input  wire                               rst_n,
	// sample stream
	input  word_t                             sample_i,
	input  wire                               sample_tag_i,
	input  wire                               sample_valid_i,
	output logic                              sample_ready_o,
	// block handshake with the host
	output logic                              block_ready_o,
	input  wire                               release_i,
	// wishbone classic slave
	input  wire                               wb_cyc_i,
	input  wire                               wb_stb_i,
	input  wire                               wb_we_i,
	input  wire  [$clog2(BLOCK_DEPTH+1)-1:0]  wb_adr_i,
	output word_t                             wb_dat_o,
	output logic                              wb_ack_o
);

	localparam int ADDR_W = $clog2(BLOCK_DEPTH + 1);

	logic              accept;
	logic              wr_en;
	logic [ADDR_W-1:0] wr_addr;
	word_t             wr_data;

	window_if win ();

	// sample taken on this edge
	assign accept = sample_valid_i && sample_ready_o;

	window_ring #(
		.WINDOW_DEPTH (WINDOW_DEPTH)
	) i_window_ring (
		.clk          (clk),
		.rst_n        (rst_n),
		.sample_i     (sample_i),
		.sample_tag_i (sample_tag_i),
		.accept_i     (accept),
		.win          (win.ring)
	);

	block_writer #(
		.WINDOW_DEPTH (WINDOW_DEPTH),
		.BLOCK_DEPTH  (BLOCK_DEPTH)
	) i_block_writer (
		.clk            (clk),
		.rst_n          (rst_n),
		.sample_valid_i (sample_valid_i),
		.sample_ready_o (sample_ready_o),
		.release_i      (release_i),
		.block_ready_o  (block_ready_o),
		.win            (win.writer),
		.wr_en_o        (wr_en),
		.wr_addr_o      (wr_addr),
		.wr_data_o      (wr_data)
	);

	block_ram #(
		.BLOCK_DEPTH (BLOCK_DEPTH)
	) i_block_ram (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en_i   (wr_en),
		.wr_addr_i (wr_addr),
		.wr_data_i (wr_data),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.wb_we_i   (wb_we_i),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_o  (wb_dat_o),
		.wb_ack_o  (wb_ack_o)
	);

endmodule

`default_nettype wire

//--- hdl/capture_pkg.sv
`default_nettype none

package capture_pkg;

	// width of one sensor sample, also the wishbone data bus
	localparam int WORD_WIDTH = 32;

	// one sample or block word
	typedef logic [WORD_WIDTH-1:0] word_t;

	// ring length in samples
	localparam int DEF_WINDOW_DEPTH = 8;

	// data entries per block, four windows worth
	localparam int DEF_BLOCK_DEPTH = 4 * DEF_WINDOW_DEPTH;

	// closes every block, sits right after the last data entry
	localparam word_t MARKER_WORD = '1;

	// block writer states
	typedef enum logic [2:0] {
		IDLE  = 3'd0,
		FETCH = 3'd1,
		STORE = 3'd2,
		PAD   = 3'd3,
		MARK  = 3'd4,
		HOLD  = 3'd5
	} writer_state_t;

endpackage

`default_nettype wire

//--- hdl/window_if.sv
`timescale 1ns/1ps
`default_nettype none

interface window_if
	import capture_pkg::*;
();

	// ring side status
	logic  stored;
	logic  armed;
	logic  quiet;
	word_t oldest;

	// writer side requests
	logic  fetch;
	logic  clear;

	modport ring (
		output stored, armed, quiet, oldest,
		input  fetch, clear
	);

	modport writer (
		input  stored, armed, quiet, oldest,
		output fetch, clear
	);

endinterface

`default_nettype wire

//--- hdl/window_ring.sv
`timescale 1ns/1ps
`default_nettype none

module window_ring
	import capture_pkg::*;
#(
	parameter int WINDOW_DEPTH = DEF_WINDOW_DEPTH
) (
	input  wire        clk,
	input  wire        rst_n,
	input  word_t      sample_i,
	input  wire        sample_tag_i,
	input  wire        accept_i,
	window_if.ring     win
);

	// pointer wraps over the ring
	localparam int PTR_W = (WINDOW_DEPTH > 1) ? $clog2(WINDOW_DEPTH) : 1;
	// run counter must reach WINDOW_DEPTH itself
	localparam int CNT_W = $clog2(WINDOW_DEPTH + 1);

	word_t                   samples [WINDOW_DEPTH];
	logic [WINDOW_DEPTH-1:0] tags;
	logic [PTR_W-1:0]        wr_ptr;
	logic [CNT_W-1:0]        run_cnt;
	logic [CNT_W-1:0]        run_next;
	logic                    stored_q;
	logic                    armed_q;
	word_t                   oldest_q;

	// consecutive tagged samples, saturating
	always_comb
	begin
		if (!sample_tag_i)
			run_next = '0;
		else if (run_cnt == CNT_W'(WINDOW_DEPTH))
			run_next = run_cnt;
		else
			run_next = run_cnt + 1'b1;
	end

	// sample storage
	always_ff @(posedge clk)
	begin
		if (accept_i)
			samples[wr_ptr] <= sample_i;
	end

	// the slot at wr_ptr is the one about to be overwritten
	always_ff @(posedge clk)
	begin
		if (win.fetch)
			oldest_q <= samples[wr_ptr];
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			tags     <= '0;
			wr_ptr   <= '0;
			run_cnt  <= '0;
			armed_q  <= 1'b0;
			stored_q <= 1'b0;
		end
		else
		begin
			// tell the writer one cycle after the write
			stored_q <= accept_i;
			if (accept_i)
			begin
				if (wr_ptr == PTR_W'(WINDOW_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (win.clear)
			begin
				// start looking for a fresh run
				tags    <= '0;
				run_cnt <= '0;
				armed_q <= 1'b0;
			end
			else if (accept_i)
			begin
				tags[wr_ptr] <= sample_tag_i;
				run_cnt      <= run_next;
				// arm on a full window of tagged samples
				if (run_next == CNT_W'(WINDOW_DEPTH))
					armed_q <= 1'b1;
			end
		end
	end

	assign win.stored = stored_q;
	assign win.armed  = armed_q;
	// break condition, no significant sample left in the ring
	assign win.quiet  = ~|tags;
	assign win.oldest = oldest_q;

	// a fetch racing a write would return the new sample, not the oldest
	a_fetch_no_write: assert property (
		@(posedge clk) disable iff (!rst_n)
		win.fetch |-> !accept_i
	);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module tb_burst_capture

status=0
./obj_dir/Vtb_burst_capture > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi
echo "simulation passed"

//--- tests/tb_burst_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tb_burst_capture
	import capture_pkg::*;
();

	localparam int WINDOW_DEPTH = DEF_WINDOW_DEPTH;
	localparam int BLOCK_DEPTH  = DEF_BLOCK_DEPTH;
	localparam int ADDR_W       = $clog2(BLOCK_DEPTH + 1);
	// cycles allowed for any single wait
	localparam int TIMEOUT      = 50;

	logic              clk = 1'b0;
	logic              rst_n;
	word_t             sample_i;
	logic              sample_tag_i;
	logic              sample_valid_i;
	logic              sample_ready_o;
	logic              block_ready_o;
	logic              release_i;
	logic              wb_cyc_i;
	logic              wb_stb_i;
	logic              wb_we_i;
	logic [ADDR_W-1:0] wb_adr_i;
	word_t             wb_dat_o;
	logic              wb_ack_o;

	// samples sent since reset or the last release
	word_t       sent_val [256];
	logic        sent_tag [256];
	int          n_sent;
	word_t       exp_words [BLOCK_DEPTH + 1];
	logic [15:0] lfsr;
	// block compare handshake between stimulus and compare process
	int          check_req;
	int          check_done;

	burst_capture_top #(
		.WINDOW_DEPTH (WINDOW_DEPTH),
		.BLOCK_DEPTH  (BLOCK_DEPTH)
	) i_burst_capture_top (
		.clk            (clk),
		.rst_n          (rst_n),
		.sample_i       (sample_i),
		.sample_tag_i   (sample_tag_i),
		.sample_valid_i (sample_valid_i),
		.sample_ready_o (sample_ready_o),
		.block_ready_o  (block_ready_o),
		.release_i      (release_i),
		.wb_cyc_i       (wb_cyc_i),
		.wb_stb_i       (wb_stb_i),
		.wb_we_i        (wb_we_i),
		.wb_adr_i       (wb_adr_i),
		.wb_dat_o       (wb_dat_o),
		.wb_ack_o       (wb_ack_o)
	);

	initial
	begin
		forever
			#20 clk = ~clk;
	end

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			$display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
			abort_run("value mismatch, stopping");
		end
	endtask

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		int          b;
		r = '0;
		for (b = 0; b < n; b++)
		begin
			lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// expected block contents for the first n samples
	// returns 1 once the block closes
	function automatic bit model_block(input int n, output word_t exp_w [BLOCK_DEPTH + 1]);
		logic [WINDOW_DEPTH-1:0] win_tags;
		int                      wp;
		int                      run;
		int                      copies;
		int                      i;
		bit                      armed;
		bit                      closed;
		win_tags = '0;
		wp       = 0;
		run      = 0;
		copies   = 0;
		armed    = 1'b0;
		closed   = 1'b0;
		for (i = 0; i <= BLOCK_DEPTH; i++)
			exp_w[i] = '0;
		for (i = 0; i < n && !closed; i++)
		begin
			win_tags[wp] = sent_tag[i];
			wp  = (wp + 1) % WINDOW_DEPTH;
			run = sent_tag[i] ? ((run < WINDOW_DEPTH) ? run + 1 : run) : 0;
			if (run == WINDOW_DEPTH)
				armed = 1'b1;
			if (win_tags == '0)
			begin
				// short blocks vanish on a break
				// longer ones get padded with zeros
				if (copies < WINDOW_DEPTH)
				begin
					copies = 0;
					armed  = 1'b0;
				end
				else
					closed = 1'b1;
			end
			else if (armed)
			begin
				// oldest of the last WINDOW_DEPTH samples
				exp_w[copies] = sent_val[i - WINDOW_DEPTH + 1];
				copies++;
				if (copies == BLOCK_DEPTH)
					closed = 1'b1;
			end
		end
		if (closed)
			exp_w[BLOCK_DEPTH] = MARKER_WORD;
		return closed;
	endfunction

	// push one sample through the handshake and compare block_ready_o with the model
	task automatic send_sample(input logic tag, output bit closed);
		word_t v;
		int    t;
		v = take_bits(32);
		t = 0;
		while (!sample_ready_o)
		begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT)
				abort_run("timeout: sample_ready_o stayed low before a sample");
		end
		sample_i       = v;
		sample_tag_i   = tag;
		sample_valid_i = 1'b1;
		sent_val[n_sent] = v;
		sent_tag[n_sent] = tag;
		n_sent++;
		@(negedge clk);
		sample_valid_i = 1'b0;
		// writer is done once ready returns or the block is held
		t = 0;
		while (!sample_ready_o && !block_ready_o)
		begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT)
				abort_run("timeout: writer never settled after a sample");
		end
		closed = model_block(n_sent, exp_words);
		check_value("block_ready_o", word_t'(block_ready_o), word_t'(closed));
	endtask

	task automatic run_until_closed(input logic tag);
		bit closed;
		int k;
		closed = 1'b0;
		for (k = 0; k < 4 * BLOCK_DEPTH && !closed; k++)
			send_sample(tag, closed);
		if (!closed)
			abort_run("block never closed");
	endtask

	// compare the held block and release it
	task automatic take_block();
		int t;
		check_req++;
		t = 0;
		while (check_done != check_req)
		begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT * (BLOCK_DEPTH + 2))
				abort_run("timeout: block compare did not finish");
		end
		release_i = 1'b1;
		@(negedge clk);
		release_i = 1'b0;
		t = 0;
		while (!sample_ready_o)
		begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT)
				abort_run("timeout: sample_ready_o stayed low after release");
		end
		check_value("block_ready_o", word_t'(block_ready_o), '0);
		n_sent = 0;
	endtask

	// wishbone classic cycle held until ack
	task automatic wb_access(input logic we, input logic [ADDR_W-1:0] adr, output word_t dat);
		int t;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = we;
		wb_adr_i = adr;
		t = 0;
		do
		begin
			@(negedge clk);
			t++;
			if (t > TIMEOUT)
				abort_run("timeout: wb_ack_o never rose");
		end
		while (!wb_ack_o);
		dat      = wb_dat_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		@(negedge clk);
	endtask

	// compare process reading every address of a held block
	initial
	begin
		word_t got;
		int    k;
		wb_cyc_i   = 1'b0;
		wb_stb_i   = 1'b0;
		wb_we_i    = 1'b0;
		wb_adr_i   = '0;
		check_done = 0;
		forever
		begin
			@(negedge clk);
			if (check_done != check_req)
			begin
				// a host write is acked but leaves the block alone
				wb_access(1'b1, '0, got);
				for (k = 0; k <= BLOCK_DEPTH; k++)
				begin
					wb_access(1'b0, ADDR_W'(k), got);
					check_value($sformatf("wb_dat_o[%0d]", k), got, exp_words[k]);
				end
				check_done++;
			end
		end
	end

	initial
	begin
		bit closed;
		int len;
		int k;
		rst_n          = 1'b0;
		sample_i       = '0;
		sample_tag_i   = 1'b0;
		sample_valid_i = 1'b0;
		release_i      = 1'b0;
		n_sent         = 0;
		check_req      = 0;
		lfsr           = 16'd42728;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("sample_ready_o", word_t'(sample_ready_o), 32'd1);
		check_value("block_ready_o", word_t'(block_ready_o), '0);
		check_value("wb_ack_o", word_t'(wb_ack_o), '0);

		// short tagged run followed by untagged samples never closes a block
		len = 1 + int'(take_bits(2));
		for (k = 0; k < len; k++)
			send_sample(1'b1, closed);
		for (k = 0; k < WINDOW_DEPTH + 2; k++)
			send_sample(1'b0, closed);

		// long run fills the block
		n_sent = 0;
		run_until_closed(1'b1);
		take_block();

		// break after a partial block pads with zeros
		len = WINDOW_DEPTH + int'(take_bits(5) % (BLOCK_DEPTH - WINDOW_DEPTH));
		for (k = 0; k < len; k++)
			send_sample(1'b1, closed);
		run_until_closed(1'b0);
		take_block();

		// broken short runs are dropped
		// the next full run starts a fresh block
		for (k = 0; k < WINDOW_DEPTH - 1; k++)
			send_sample(1'b1, closed);
		send_sample(1'b0, closed);
		for (k = 0; k < WINDOW_DEPTH - 1; k++)
			send_sample(1'b1, closed);
		for (k = 0; k < WINDOW_DEPTH; k++)
			send_sample(1'b0, closed);
		run_until_closed(1'b1);
		take_block();

		if (check_done == check_req)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
hdl/capture_pkg.sv
hdl/window_if.sv
hdl/window_ring.sv
hdl/block_writer.sv
hdl/block_ram.sv
hdl/burst_capture_top.sv
tests/tb_burst_capture.sv
